//--- soc_bus_config.svh
`ifndef SOC_BUS_CONFIG_SVH
`define SOC_BUS_CONFIG_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// upper address half that selects each slave
`define DMEM_BASE_HI 16'h0010
`define UART_BASE_HI 16'h0100

// data memory is 256 words, 0x400 bytes
`define DMEM_WORDS 256

// uart register offsets within its region
`define UART_TXDATA_OFS 16'h0000
`define UART_STATUS_OFS 16'h0004
`define UART_DIV_OFS    16'h0008

// transmit FIFO depth, power of two
`define UART_FIFO_DEPTH 8

// bit period in clocks after reset
`define UART_DIV_RESET 16

`endif

//--- soc_bus_pkg.sv
`include "soc_bus_config.svh"

package soc_bus_pkg;

  typedef logic [`SOC_ADDR_W-1:0]   wb_addr_t;
  typedef logic [`SOC_DATA_W-1:0]   wb_data_t;
  typedef logic [`SOC_DATA_W/8-1:0] wb_sel_t;
  typedef logic [7:0]               uart_byte_t;

  // master to slave, one classic cycle
  typedef struct packed {
    logic     cyc;
    logic     stb;
    wb_addr_t adr;
    logic     we;
    wb_data_t dat;
    wb_sel_t  sel;
  } wb_req_t;

  // slave to master, ack and err are never high together
  typedef struct packed {
    wb_data_t dat;
    logic     ack;
    logic     err;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

//--- wb_interconnect.sv
`include "soc_bus_config.svh"

module wb_interconnect (
  input  logic                 clk,
  input  logic                 rst_n,
  input  soc_bus_pkg::wb_req_t m_req,
  output soc_bus_pkg::wb_rsp_t m_rsp,
  output soc_bus_pkg::wb_req_t dmem_req,
  input  soc_bus_pkg::wb_rsp_t dmem_rsp,
  output soc_bus_pkg::wb_req_t uart_req,
  input  soc_bus_pkg::wb_rsp_t uart_rsp
);

  logic dmem_hit;
  logic uart_hit;
  logic unmapped_cyc;
  logic unmapped_err;

  // upper half picks the peripheral, lower half is the offset inside it
  assign dmem_hit = (m_req.adr[31:16] == `DMEM_BASE_HI);
  assign uart_hit = (m_req.adr[31:16] == `UART_BASE_HI);

  // nobody decodes this address, so the fabric answers itself
  assign unmapped_cyc = m_req.cyc && m_req.stb && !dmem_hit && !uart_hit;

  // one err pulse per strobe, held strobe is not answered twice
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      unmapped_err <= 1'b0;
    end else begin
      unmapped_err <= unmapped_cyc && !unmapped_err;
    end
  end

  // shared fields go to both slaves, cyc and stb only to the hit
  always_comb begin
    dmem_req     = m_req;
    dmem_req.cyc = m_req.cyc && dmem_hit;
    dmem_req.stb = m_req.stb && dmem_hit;

    uart_req     = m_req;
    uart_req.cyc = m_req.cyc && uart_hit;
    uart_req.stb = m_req.stb && uart_hit;
  end

  // response mux, zero data when no slave is selected
  always_comb begin
    m_rsp = '0;
    if (dmem_hit) begin
      m_rsp = dmem_rsp;
    end else if (uart_hit) begin
      m_rsp = uart_rsp;
    end else begin
      m_rsp.err = unmapped_err;
    end
  end

endmodule

//--- wb_dmem.sv
`include "soc_bus_config.svh"

module wb_dmem (
  input  logic                 clk,
  input  logic                 rst_n,
  input  soc_bus_pkg::wb_req_t req,
  output soc_bus_pkg::wb_rsp_t rsp
);

  localparam int idx_w = $clog2(`DMEM_WORDS);
  localparam int sel_w = `SOC_DATA_W / 8;

  soc_bus_pkg::wb_data_t mem [`DMEM_WORDS];
  soc_bus_pkg::wb_data_t rd_data;
  logic [idx_w-1:0]      idx;
  logic                  in_range;
  logic                  access;
  logic                  ack_q;
  logic                  err_q;

  // word index sits above the byte offset
  assign idx      = req.adr[idx_w+1:2];
  assign in_range = (req.adr[15:0] < 16'(`DMEM_WORDS * 4));

  // first cycle of a strobe only
  assign access = req.cyc && req.stb && !ack_q && !err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access && in_range;
      err_q <= access && !in_range;
    end
  end

  // byte lanes written only where sel is set
  always_ff @(posedge clk) begin
    if (access && in_range && req.we) begin
      for (int b = 0; b < sel_w; b++) begin
        if (req.sel[b]) begin
          mem[idx][8*b +: 8] <= req.dat[8*b +: 8];
        end
      end
    end
  end

  // read data lands together with ack
  always_ff @(posedge clk) begin
    if (access && in_range && !req.we) begin
      rd_data <= mem[idx];
    end
  end

  assign rsp.dat = rd_data;
  assign rsp.ack = ack_q;
  assign rsp.err = err_q;

endmodule

//--- wb_uart.sv
`include "soc_bus_config.svh"

module wb_uart (
  input  logic                    clk,
  input  logic                    rst_n,
  input  soc_bus_pkg::wb_req_t    req,
  output soc_bus_pkg::wb_rsp_t    rsp,
  output logic                    push,
  output soc_bus_pkg::uart_byte_t push_byte,
  input  logic                    fifo_full,
  input  logic                    fifo_empty,
  output soc_bus_pkg::wb_data_t   divisor,
  input  logic                    tx_busy
);

  logic [15:0]           ofs;
  logic                  access;
  logic                  is_tx;
  logic                  is_stat;
  logic                  is_div;
  logic                  bad;
  logic                  ack_q;
  logic                  err_q;
  logic [15:0]           div_q;
  soc_bus_pkg::wb_data_t rd_data;

  assign ofs    = req.adr[15:0];
  assign access = req.cyc && req.stb && !ack_q && !err_q;

  assign is_tx   = (ofs == `UART_TXDATA_OFS);
  assign is_stat = (ofs == `UART_STATUS_OFS);
  assign is_div  = (ofs == `UART_DIV_OFS);

  // unknown offset, write to status, or tx write with no room
  assign bad = !(is_tx || is_stat || is_div)
             || (is_stat && req.we)
             || (is_tx && req.we && fifo_full);

  // byte enters the FIFO on the same edge that raises ack
  assign push      = access && is_tx && req.we && !fifo_full;
  assign push_byte = req.dat[7:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      div_q <= 16'(`UART_DIV_RESET);
    end else begin
      ack_q <= access && !bad;
      err_q <= access && bad;
      if (access && !bad && req.we && is_div) begin
        if (req.sel[0]) begin
          div_q[7:0] <= req.dat[7:0];
        end
        if (req.sel[1]) begin
          div_q[15:8] <= req.dat[15:8];
        end
      end
    end
  end

  // tx data reads back as zero
  always_ff @(posedge clk) begin
    if (access && !req.we) begin
      if (is_stat) begin
        rd_data <= {{(`SOC_DATA_W-3){1'b0}}, tx_busy, fifo_full, fifo_empty};
      end else if (is_div) begin
        rd_data <= {{(`SOC_DATA_W-16){1'b0}}, div_q};
      end else begin
        rd_data <= '0;
      end
    end
  end

  assign divisor = {{(`SOC_DATA_W-16){1'b0}}, div_q};

  assign rsp.dat = rd_data;
  assign rsp.ack = ack_q;
  assign rsp.err = err_q;

endmodule

//--- uart_tx_fifo.sv
`include "soc_bus_config.svh"

module uart_tx_fifo #(
  parameter int depth = `UART_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,
  input  soc_bus_pkg::uart_byte_t push_byte,
  input  logic                    pop,
  output soc_bus_pkg::uart_byte_t head_byte,
  output logic                    full,
  output logic                    empty
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  soc_bus_pkg::uart_byte_t mem [depth];
  logic [ptr_w-1:0]        wr_ptr;
  logic [ptr_w-1:0]        rd_ptr;
  logic [cnt_w-1:0]        count;
  logic [cnt_w-1:0]        count_next;
  logic                    do_push;
  logic                    do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= (count_next == cnt_w'(depth));
      empty <= (count_next == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_byte;
    end
  end

  // head is visible without a read cycle
  assign head_byte = mem[rd_ptr];

endmodule

//--- uart_tx.sv
module uart_tx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  soc_bus_pkg::wb_data_t   divisor,
  input  logic                    fifo_empty,
  input  soc_bus_pkg::uart_byte_t head_byte,
  output logic                    pop,
  output logic                    busy,
  output logic                    txd
);

  soc_bus_pkg::tx_state_t  state;
  soc_bus_pkg::wb_data_t   bit_cnt;
  soc_bus_pkg::wb_data_t   period_m1;
  soc_bus_pkg::uart_byte_t shreg;
  logic [2:0]              bit_idx;
  logic                    bit_done;

  // a divisor of zero behaves like one
  assign period_m1 = (divisor == '0) ? '0 : divisor - 1'b1;
  assign bit_done  = (bit_cnt == '0);

  assign pop  = (state == soc_bus_pkg::TX_IDLE) && !fifo_empty;
  assign busy = (state != soc_bus_pkg::TX_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= soc_bus_pkg::TX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;
    end else begin
      if (state != soc_bus_pkg::TX_IDLE && !bit_done) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
      case (state)
        soc_bus_pkg::TX_IDLE: begin
          // head byte is taken on the pop edge, start bit begins here
          if (pop) begin
            state   <= soc_bus_pkg::TX_START;
            bit_cnt <= period_m1;
            txd     <= 1'b0;
          end
        end
        soc_bus_pkg::TX_START: begin
          if (bit_done) begin
            state   <= soc_bus_pkg::TX_DATA;
            bit_cnt <= period_m1;
            bit_idx <= '0;
            txd     <= shreg[0];
          end
        end
        soc_bus_pkg::TX_DATA: begin
          if (bit_done) begin
            bit_cnt <= period_m1;
            if (bit_idx == 3'd7) begin
              state <= soc_bus_pkg::TX_STOP;
              txd   <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              txd     <= shreg[0];
            end
          end
        end
        default: begin
          if (bit_done) begin
            state <= soc_bus_pkg::TX_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first, next bit always sits in shreg[0]
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= head_byte;
    end else if (bit_done && (state == soc_bus_pkg::TX_START || state == soc_bus_pkg::TX_DATA)) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

//--- soc_bus_top.sv
module soc_bus_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  soc_bus_pkg::wb_req_t wb_req,
  output soc_bus_pkg::wb_rsp_t wb_rsp,
  output logic                 uart_txd
);

  soc_bus_pkg::wb_req_t    dmem_req;
  soc_bus_pkg::wb_rsp_t    dmem_rsp;
  soc_bus_pkg::wb_req_t    uart_req;
  soc_bus_pkg::wb_rsp_t    uart_rsp;
  logic                    push;
  soc_bus_pkg::uart_byte_t push_byte;
  logic                    pop;
  soc_bus_pkg::uart_byte_t head_byte;
  logic                    fifo_full;
  logic                    fifo_empty;
  soc_bus_pkg::wb_data_t   divisor;
  logic                    tx_busy;

  wb_interconnect u_interconnect (
    .clk      (clk),
    .rst_n    (rst_n),
    .m_req    (wb_req),
    .m_rsp    (wb_rsp),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp),
    .uart_req (uart_req),
    .uart_rsp (uart_rsp)
  );

  wb_dmem u_dmem (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (dmem_req),
    .rsp   (dmem_rsp)
  );

  wb_uart u_uart (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (uart_req),
    .rsp        (uart_rsp),
    .push       (push),
    .push_byte  (push_byte),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty),
    .divisor    (divisor),
    .tx_busy    (tx_busy)
  );

  uart_tx_fifo u_tx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_byte (push_byte),
    .pop       (pop),
    .head_byte (head_byte),
    .full      (fifo_full),
    .empty     (fifo_empty)
  );

  uart_tx u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .divisor    (divisor),
    .fifo_empty (fifo_empty),
    .head_byte  (head_byte),
    .pop        (pop),
    .busy       (tx_busy),
    .txd        (uart_txd)
  );

endmodule

//--- tb_soc_bus.sv
`include "soc_bus_config.svh"

module tb_soc_bus;

  timeunit 1ns;
  timeprecision 100ps;

  // one bus access and what the master should get back
  typedef struct packed {
    logic                  we;
    soc_bus_pkg::wb_addr_t adr;
    soc_bus_pkg::wb_data_t dat;
    soc_bus_pkg::wb_sel_t  sel;
    soc_bus_pkg::wb_data_t exp_dat;
    logic                  exp_err;
    logic                  chk_dat;
    logic                  drain;
  } entry_t;

  localparam soc_bus_pkg::wb_addr_t uart_tx_adr   = {`UART_BASE_HI, `UART_TXDATA_OFS};
  localparam soc_bus_pkg::wb_addr_t uart_stat_adr = {`UART_BASE_HI, `UART_STATUS_OFS};
  localparam soc_bus_pkg::wb_addr_t uart_div_adr  = {`UART_BASE_HI, `UART_DIV_OFS};
  localparam soc_bus_pkg::wb_addr_t uart_bad_adr  = {`UART_BASE_HI, 16'h000C};
  localparam soc_bus_pkg::wb_addr_t unmapped_adr  = 32'h0200_0000;

  logic                    clk;
  logic                    rst_n;
  soc_bus_pkg::wb_req_t    wb_req;
  soc_bus_pkg::wb_rsp_t    wb_rsp;
  logic                    uart_txd;

  entry_t                  stim[$];
  soc_bus_pkg::uart_byte_t exp_bytes[$];
  soc_bus_pkg::uart_byte_t rx_bytes[$];
  int                      seed;
  int                      cur_div;
  int                      max_div;
  int                      sent_total;
  int                      bytes_sent;
  int                      frames_done;
  logic                    table_ready;

  always #2 clk = ~clk;

  soc_bus_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .uart_txd (uart_txd)
  );

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // a set sel bit takes the new byte, a clear one keeps the old byte
  function automatic soc_bus_pkg::wb_data_t merge_bytes(input soc_bus_pkg::wb_data_t old_w,
                                                        input soc_bus_pkg::wb_data_t new_w,
                                                        input soc_bus_pkg::wb_sel_t sel);
    soc_bus_pkg::wb_data_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  // addresses spread over the memory and the last one is the top word
  function automatic soc_bus_pkg::wb_addr_t word_adr(input int i);
    logic [15:0] ofs;
    ofs = (i == 7) ? 16'h03FC : 16'(i * 'h84);
    return {`DMEM_BASE_HI, ofs};
  endfunction

  task automatic add_entry(input logic we, input soc_bus_pkg::wb_addr_t adr,
                           input soc_bus_pkg::wb_data_t dat, input soc_bus_pkg::wb_sel_t sel,
                           input soc_bus_pkg::wb_data_t exp_dat, input logic exp_err,
                           input logic chk_dat, input logic drain);
    stim.push_back(entry_t'{we, adr, dat, sel, exp_dat, exp_err, chk_dat, drain});
    if (we && !exp_err && adr == uart_tx_adr) begin
      sent_total++;
    end
    if (we && !exp_err && adr == uart_div_adr && int'(dat[15:0]) > max_div) begin
      max_div = int'(dat[15:0]);
    end
  endtask

  task automatic build_stimulus();
    soc_bus_pkg::wb_data_t model [8];
    soc_bus_pkg::wb_data_t d;
    soc_bus_pkg::wb_data_t r;
    // uart registers straight out of reset
    add_entry(1'b0, uart_div_adr, '0, 4'hF, `UART_DIV_RESET, 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, uart_stat_adr, '0, 4'hF, 32'h1, 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, uart_tx_adr, '0, 4'hF, '0, 1'b0, 1'b1, 1'b0);
    // full word first, then a random byte mix on top
    for (int i = 0; i < 8; i++) begin
      d = $random(seed);
      add_entry(1'b1, word_adr(i), d, 4'hF, '0, 1'b0, 1'b0, 1'b0);
      model[i] = d;
      d = $random(seed);
      r = $random(seed);
      add_entry(1'b1, word_adr(i), d, r[3:0], '0, 1'b0, 1'b0, 1'b0);
      model[i] = merge_bytes(model[i], d, r[3:0]);
    end
    for (int i = 0; i < 8; i++) begin
      add_entry(1'b0, word_adr(i), '0, 4'hF, model[i], 1'b0, 1'b1, 1'b0);
    end
    // 0x400 and 0x404 would alias words 0 and 1 without the decode error
    add_entry(1'b0, unmapped_adr, '0, 4'hF, '0, 1'b1, 1'b1, 1'b0);
    add_entry(1'b1, unmapped_adr, 32'hDEAD_BEEF, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, {`DMEM_BASE_HI, 16'h0400}, 32'hDEAD_BEEF, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, {`DMEM_BASE_HI, 16'h0404}, 32'hCAFE_F00D, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b0, {`DMEM_BASE_HI, 16'h0400}, '0, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, uart_bad_adr, 32'h0000_0055, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b0, uart_bad_adr, '0, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b1, uart_stat_adr, 32'h0000_0007, 4'hF, '0, 1'b1, 1'b0, 1'b0);
    add_entry(1'b0, word_adr(0), '0, 4'hF, model[0], 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, word_adr(1), '0, 4'hF, model[1], 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, word_adr(7), '0, 4'hF, model[7], 1'b0, 1'b1, 1'b0);
    // serial frames at divisor 4 where only the low byte of each word is sent
    add_entry(1'b1, uart_div_adr, 32'd4, 4'hF, '0, 1'b0, 1'b0, 1'b0);
    add_entry(1'b0, uart_div_adr, '0, 4'hF, 32'd4, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < 4; i++) begin
      d = $random(seed);
      add_entry(1'b1, uart_tx_adr, d, 4'hF, '0, 1'b0, 1'b0, 1'b0);
    end
    // back-pressure with one byte in the serializer and eight in the FIFO
    add_entry(1'b1, uart_div_adr, 32'd200, 4'hF, '0, 1'b0, 1'b0, 1'b1);
    for (int i = 0; i < 10; i++) begin
      add_entry(1'b1, uart_tx_adr, 32'h41 + i, 4'hF, '0, (i == 9), 1'b0, 1'b0);
    end
    add_entry(1'b0, uart_stat_adr, '0, 4'hF, 32'h6, 1'b0, 1'b1, 1'b0);
    add_entry(1'b0, uart_stat_adr, '0, 4'hF, 32'h1, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic apply_entry(input entry_t e);
    int waited;
    if (e.drain) begin
      wait (frames_done == bytes_sent);
      // rest of the last stop bit, then the transmitter is idle
      repeat (cur_div / 2 + 2) @(posedge clk);
    end
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.adr = e.adr;
    wb_req.we  = e.we;
    wb_req.dat = e.dat;
    wb_req.sel = e.sel;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_rsp.ack && !wb_rsp.err && waited < 16);
    check_equal(waited, 1, "response latency in cycles");
    check_equal(32'(wb_rsp.err), 32'(e.exp_err), "err");
    check_equal(32'(wb_rsp.ack), 32'(!e.exp_err), "ack");
    if (e.chk_dat) begin
      check_equal(wb_rsp.dat, e.exp_dat, "read data");
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    if (e.we && !e.exp_err && e.adr == uart_tx_adr) begin
      exp_bytes.push_back(e.dat[7:0]);
      bytes_sent++;
    end
    if (e.we && !e.exp_err && e.adr == uart_div_adr) begin
      cur_div = int'(e.dat[15:0]);
    end
  endtask

  // each falling edge of the idle line starts an 8N1 frame sampled mid bit
  initial begin : serial_monitor
    int                      div;
    soc_bus_pkg::uart_byte_t rx;
    forever begin
      @(negedge uart_txd);
      div = cur_div;
      repeat (div / 2) @(posedge clk);
      #1;
      check_equal(32'(uart_txd), 0, "start bit");
      for (int b = 0; b < 8; b++) begin
        repeat (div) @(posedge clk);
        #1;
        rx[b] = uart_txd;
      end
      repeat (div) @(posedge clk);
      #1;
      check_equal(32'(uart_txd), 1, "stop bit");
      rx_bytes.push_back(rx);
      frames_done++;
    end
  end

  initial begin : watchdog
    longint limit;
    wait (table_ready);
    limit = (longint'(stim.size()) * 8
           + longint'(sent_total) * 10 * longint'(max_div) + 2000) * 4;
    #(limit);
    $display("timeout: the run did not finish within %0d ns", limit);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_req      = '0;
    seed        = 24;
    cur_div     = `UART_DIV_RESET;
    max_div     = `UART_DIV_RESET;
    sent_total  = 0;
    bytes_sent  = 0;
    frames_done = 0;
    table_ready = 1'b0;
    build_stimulus();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    wait (frames_done == bytes_sent);
    check_equal(rx_bytes.size(), exp_bytes.size(), "byte count on uart_txd");
    foreach (exp_bytes[i]) begin
      check_equal(32'(rx_bytes[i]), 32'(exp_bytes[i]), "byte on uart_txd");
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
soc_bus_pkg.sv
wb_interconnect.sv
wb_dmem.sv
wb_uart.sv
uart_tx_fifo.sv
uart_tx.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- Makefile
TOP := tb_soc_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP) \
	  --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
	  echo "simulation reported a failure"; \
	  exit 1; \
	fi
	@if ! grep -q "Regression passed" sim.log; then \
	  echo "simulation ended without a result"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
